// ==== hdl/biquad_types_pkg.sv ====
package biquad_types_pkg;

    // Fixed-point formats of the biquad datapath
    // Samples and coefficients are Q2.14, products Q4.28
    // The accumulator keeps four guard bits above the product, Q8.28

    typedef logic signed [15:0] sample_t;   // Audio sample, Q2.14
    typedef logic signed [15:0] coef_t;     // Filter coefficient, Q2.14
    typedef logic signed [31:0] product_t;  // Coef times sample, Q4.28
    typedef logic signed [35:0] acc_t;      // Five-term sum, Q8.28

    // Fractional bits of a sample or coefficient
    localparam int frac_bits = 14;

    // Static coefficient set, held stable while the filter runs
    // Feedback terms are given as a1/a2 and subtracted in the datapath
    typedef struct packed {
        coef_t b0;  // Feed-forward x[n]
        coef_t b1;  // Feed-forward x[n-1]
        coef_t b2;  // Feed-forward x[n-2]
        coef_t a1;  // Feedback y[n-1]
        coef_t a2;  // Feedback y[n-2]
    } biquad_coefs_t;

    // The two factors for the tap in flight
    typedef struct packed {
        coef_t   coef;  // Already negated for a1/a2
        sample_t data;  // Matching history entry
    } mac_operands_t;

endpackage

// ==== hdl/biquad_ctrl_pkg.sv ====
package biquad_ctrl_pkg;

    // Sequencer states, one per cycle of a filter pass
    typedef enum logic [3:0] {
        idle   = 4'd0,  // Waiting for a word-clock edge
        load   = 4'd1,  // History settles, accumulator cleared
        tap_b0 = 4'd2,
        tap_b1 = 4'd3,
        tap_b2 = 4'd4,
        tap_a1 = 4'd5,
        tap_a2 = 4'd6,
        drain  = 4'd7,  // Last product still in the multiplier register
        done   = 4'd8   // Sum complete, quantizer samples it
    } seq_state_t;

    // Which coefficient/history pair feeds the multiplier
    typedef enum logic [2:0] {
        sel_b0 = 3'd0,
        sel_b1 = 3'd1,
        sel_b2 = 3'd2,
        sel_a1 = 3'd3,
        sel_a2 = 3'd4
    } tap_sel_t;

    // Sequencer to datapath control word
    typedef struct packed {
        logic     clear;  // Zero the MAC pipeline
        logic     en;     // Operands valid this cycle
        tap_sel_t tap;    // Operand select for the tap store
    } mac_ctrl_t;

endpackage

// ==== hdl/biquad_sequencer.sv ====
`timescale 1ns/1ns

module biquad_sequencer #(
    parameter int SYNC_STAGES = 2  // Word-clock synchronizer depth, at least 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       l_r_clk,        // Slow left/right word clock
    output logic                       sample_strobe,  // Shift latest_sample into x history
    output biquad_ctrl_pkg::mac_ctrl_t mac_ctrl,
    output logic                       result_strobe   // Accumulator holds y[n]
);

    import biquad_ctrl_pkg::*;

    logic [SYNC_STAGES-1:0] lr_sync;  // Bit 0 sees l_r_clk first
    logic                   lr_edge;  // Either edge of the word clock
    seq_state_t             state;
    seq_state_t             next_state;

    // Word clock is asynchronous to clk
    always_ff @(posedge clk) begin
        if (!reset) begin
            lr_sync <= '0;
        end else begin
            lr_sync <= {lr_sync[SYNC_STAGES-2:0], l_r_clk};
        end
    end

    // Last two stages differ for exactly one cycle per transition
    assign lr_edge = lr_sync[SYNC_STAGES-1] ^ lr_sync[SYNC_STAGES-2];

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // One pass per edge; edges outside idle are dropped
    always_comb begin
        next_state = state;
        case (state)
            idle:    if (lr_edge) next_state = load;
            load:    next_state = tap_b0;
            tap_b0:  next_state = tap_b1;
            tap_b1:  next_state = tap_b2;
            tap_b2:  next_state = tap_a1;
            tap_a1:  next_state = tap_a2;
            tap_a2:  next_state = drain;
            drain:   next_state = done;
            done:    next_state = idle;
            default: next_state = idle;
        endcase
    end

    assign sample_strobe = (state == idle) && lr_edge;  // Same cycle as the edge
    assign result_strobe = (state == done);

    // Control word decoded straight from the state
    always_comb begin
        mac_ctrl.clear = (state == load);  // Accumulator starts each pass at zero
        mac_ctrl.en    = (state inside {tap_b0, tap_b1, tap_b2, tap_a1, tap_a2});
        case (state)
            tap_b1:  mac_ctrl.tap = sel_b1;
            tap_b2:  mac_ctrl.tap = sel_b2;
            tap_a1:  mac_ctrl.tap = sel_a1;
            tap_a2:  mac_ctrl.tap = sel_a2;
            default: mac_ctrl.tap = sel_b0;  // Don't care while en is low
        endcase
    end

    // Edge while a pass is running breaks the minimum word-clock spacing
    a_edge_in_idle: assert property (
        @(posedge clk) disable iff (!reset)
        lr_edge |-> (state == idle)
    ) else $error("l_r_clk edge during filter pass, edge ignored");

    // Enable burst follows the clear and lasts exactly the five taps
    a_en_in_taps: assert property (
        @(posedge clk) disable iff (!reset)
        $rose(mac_ctrl.en) |-> $past(mac_ctrl.clear) ##1 mac_ctrl.en [*4] ##1 !mac_ctrl.en
    ) else $error("MAC enable outside the five tap cycles");

    // Product register plus accumulate stage, then result sampled
    a_result_after_a2: assert property (
        @(posedge clk) disable iff (!reset)
        (state == tap_a2) |-> ##2 result_strobe
    ) else $error("result_strobe not two cycles after last tap");

endmodule

// ==== hdl/tap_store.sv ====
`timescale 1ns/1ns

module tap_store (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           sample_strobe,    // New x[n] arrives
    input  biquad_types_pkg::sample_t      latest_sample,
    input  logic                           out_valid,        // New y[n] arrives
    input  biquad_types_pkg::sample_t      filtered_output,
    input  biquad_types_pkg::biquad_coefs_t coefs,
    input  biquad_ctrl_pkg::tap_sel_t      tap,
    output biquad_types_pkg::mac_operands_t operands
);

    import biquad_types_pkg::*;
    import biquad_ctrl_pkg::*;

    localparam coef_t coef_min = {1'b1, {($bits(coef_t)-1){1'b0}}};  // -2.0
    localparam coef_t coef_max = {1'b0, {($bits(coef_t)-1){1'b1}}};  // Just under +2.0

    sample_t x_n, x_n1, x_n2;  // Input history
    sample_t y_n1, y_n2;       // Output history

    // -2.0 has no positive counterpart in Q2.14
    function automatic coef_t neg_sat(input coef_t c);
        return (c == coef_min) ? coef_max : -c;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset) begin
            x_n  <= '0;
            x_n1 <= '0;
            x_n2 <= '0;
        end else if (sample_strobe) begin
            x_n  <= latest_sample;
            x_n1 <= x_n;
            x_n2 <= x_n1;
        end
    end

    // Both channels share this history
    always_ff @(posedge clk) begin
        if (!reset) begin
            y_n1 <= '0;
            y_n2 <= '0;
        end else if (out_valid) begin
            y_n1 <= filtered_output;
            y_n2 <= y_n1;
        end
    end

    // Feedback taps are subtracted, so their coefficients go in negated
    always_comb begin
        case (tap)
            sel_b1: begin
                operands.coef = coefs.b1;
                operands.data = x_n1;
            end
            sel_b2: begin
                operands.coef = coefs.b2;
                operands.data = x_n2;
            end
            sel_a1: begin
                operands.coef = neg_sat(coefs.a1);
                operands.data = y_n1;
            end
            sel_a2: begin
                operands.coef = neg_sat(coefs.a2);
                operands.data = y_n2;
            end
            default: begin
                operands.coef = coefs.b0;
                operands.data = x_n;
            end
        endcase
    end

    // Result then deviates slightly from the ideal recursion
    a_fb_coef_clip: assert property (
        @(posedge clk) disable iff (!reset)
        ((tap == sel_a1) && (coefs.a1 == coef_min)) == 1'b0 &&
        ((tap == sel_a2) && (coefs.a2 == coef_min)) == 1'b0
    ) else $warning("Feedback coefficient -2.0 clipped on negation");

endmodule

// ==== hdl/mac_accum.sv ====
`timescale 1ns/1ns

module mac_accum (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            clear,     // Start of a new pass
    input  logic                            en,        // Operands valid this cycle
    input  biquad_types_pkg::mac_operands_t operands,
    output biquad_types_pkg::acc_t          acc        // Running Q8.28 sum
);

    import biquad_types_pkg::*;

    product_t product_q;  // Stage 1, Q4.28
    logic     en_q;       // Product register holds a fresh term

    // Stage 1 multiplies, stage 2 accumulates one cycle later
    always_ff @(posedge clk) begin
        if (!reset) begin
            product_q <= '0;
            en_q      <= 1'b0;
            acc       <= '0;
        end else if (clear) begin
            product_q <= '0;  // Nothing stale left in the pipe
            en_q      <= 1'b0;
            acc       <= '0;
        end else begin
            if (en) begin
                product_q <= operands.coef * operands.data;  // Signed 16x16 into 32
            end
            en_q <= en;
            if (en_q) begin
                acc <= acc + acc_t'(product_q);  // Sign-extended into guard bits
            end
        end
    end

    // Clear would discard the term being multiplied
    a_clear_en_exclusive: assert property (
        @(posedge clk) disable iff (!reset)
        !(clear && en)
    ) else $error("MAC clear and enable asserted together");

    // Each pass adds exactly the five taps after a clear
    a_five_terms: assert property (
        @(posedge clk) disable iff (!reset)
        clear |=> (!en_q [*1] ##1 en_q [*5] ##1 !en_q)
    ) else $error("MAC pass did not accumulate five consecutive terms");

endmodule

// ==== hdl/output_quantizer.sv ====
`timescale 1ns/1ns

module output_quantizer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       result_strobe,    // acc holds the finished sum
    input  biquad_types_pkg::acc_t     acc,
    output biquad_types_pkg::sample_t  filtered_output,  // y[n], Q2.14
    output logic                       out_valid         // One cycle per result
);

    import biquad_types_pkg::*;

    localparam int    shift_w  = $bits(acc_t) - frac_bits;  // Width after dropping fraction
    localparam int    samp_w   = $bits(sample_t);
    localparam sample_t sat_pos = {1'b0, {(samp_w-1){1'b1}}};  // +32767
    localparam sample_t sat_neg = {1'b1, {(samp_w-1){1'b0}}};  // -32768

    logic signed [shift_w-1:0] shifted;   // Q8.14, truncated toward minus infinity
    logic [shift_w-samp_w:0]   head;      // Sign bit of the result plus the bits above
    logic                      fits;
    sample_t                   quantized;

    assign shifted = acc[$bits(acc_t)-1:frac_bits];
    assign head    = shifted[shift_w-1:samp_w-1];
    assign fits    = (&head) | ~(|head);  // All ones or all zeros

    // Clamp instead of wrapping into the other sign
    always_comb begin
        if (fits) begin
            quantized = shifted[samp_w-1:0];
        end else if (shifted[shift_w-1]) begin
            quantized = sat_neg;
        end else begin
            quantized = sat_pos;
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            filtered_output <= '0;
            out_valid       <= 1'b0;
        end else begin
            out_valid <= result_strobe;
            if (result_strobe) filtered_output <= quantized;  // Held until the next pass
        end
    end

endmodule

// ==== hdl/biquad_filter_top.sv ====
`timescale 1ns/1ns

module biquad_filter_top #(
    parameter int SYNC_STAGES = 2  // l_r_clk synchronizer depth
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            l_r_clk,          // New sample on each edge
    input  biquad_types_pkg::sample_t       latest_sample,    // x[n]
    input  biquad_types_pkg::biquad_coefs_t coefs,            // Static Q2.14 set
    output biquad_types_pkg::sample_t       filtered_output,  // y[n]
    output logic                            out_valid
);

    import biquad_types_pkg::*;
    import biquad_ctrl_pkg::*;

    logic          sample_strobe;
    logic          result_strobe;
    mac_ctrl_t     mac_ctrl;
    mac_operands_t operands;
    acc_t          acc;

    // Edge detect and tap sequencing
    biquad_sequencer #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_sequencer (
        .clk           (clk),
        .reset         (reset),
        .l_r_clk       (l_r_clk),
        .sample_strobe (sample_strobe),
        .mac_ctrl      (mac_ctrl),
        .result_strobe (result_strobe)
    );

    // History and operand select, y fed back from the quantizer
    tap_store u_tap_store (
        .clk             (clk),
        .reset           (reset),
        .sample_strobe   (sample_strobe),
        .latest_sample   (latest_sample),
        .out_valid       (out_valid),
        .filtered_output (filtered_output),
        .coefs           (coefs),
        .tap             (mac_ctrl.tap),
        .operands        (operands)
    );

    mac_accum u_mac_accum (
        .clk      (clk),
        .reset    (reset),
        .clear    (mac_ctrl.clear),
        .en       (mac_ctrl.en),
        .operands (operands),
        .acc      (acc)
    );

    output_quantizer u_output_quantizer (
        .clk             (clk),
        .reset           (reset),
        .result_strobe   (result_strobe),
        .acc             (acc),
        .filtered_output (filtered_output),
        .out_valid       (out_valid)
    );

endmodule

// ==== dv/tb_biquad.sv ====
`timescale 1ns/1ns

module tb_biquad;

    import biquad_types_pkg::*;

    localparam int clk_half      = 20;  // 40 ns period
    localparam int reset_cycles  = 4;
    localparam int lr_period     = 16;  // clk cycles between word-clock edges
    localparam int total_samples = 96;  // Sum over all tests below
    localparam longint watchdog_ns =
        longint'(total_samples) * lr_period * 2 * clk_half + 400 * 2 * clk_half;

    logic          clk = 1'b0;
    logic          reset;
    logic          l_r_clk;
    sample_t       latest_sample;
    biquad_coefs_t coefs;
    sample_t       filtered_output;
    logic          out_valid;

    // Reference model state, one shared history like the DUT
    sample_t mx0, mx1, mx2;
    sample_t my1, my2;
    sample_t exp_q[$];   // Expected outputs in arrival order
    sample_t exp_head;   // Head of exp_q, read by the assertions
    int      exp_count;
    logic    pop_req;    // Head was checked on the last rising edge

    int errors       = 0;
    int toggles      = 0;  // Word-clock transitions driven
    int pulses       = 0;  // out_valid pulses seen
    int tests_passed = 0;
    int tests_failed = 0;

    biquad_filter_top #(
        .SYNC_STAGES (2)
    ) dut (
        .clk             (clk),
        .reset           (reset),
        .l_r_clk         (l_r_clk),
        .latest_sample   (latest_sample),
        .coefs           (coefs),
        .filtered_output (filtered_output),
        .out_valid       (out_valid)
    );

    always #clk_half clk = ~clk;

    // Floor shift back to Q2.14, clamp to 16 bits
    function automatic sample_t quantize(input longint v);
        longint s;
        s = v >>> frac_bits;
        if (s > 32767) return 16'sh7fff;
        if (s < -32768) return 16'sh8000;
        return sample_t'(s);
    endfunction

    function automatic coef_t small_coef();
        return coef_t'(int'($urandom_range(8190)) - 4095);  // |c| < 4096
    endfunction

    task automatic refresh_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : '0;
    endtask

    task automatic clear_model();
        mx0 = '0;
        mx1 = '0;
        mx2 = '0;
        my1 = '0;
        my2 = '0;
    endtask

    // Direct form I in full precision, feedback subtracted
    task automatic model_step(input sample_t s);
        longint  sum;
        sample_t y;
        mx2 = mx1;
        mx1 = mx0;
        mx0 = s;
        sum = longint'(coefs.b0) * longint'(mx0) + longint'(coefs.b1) * longint'(mx1)
            + longint'(coefs.b2) * longint'(mx2) - longint'(coefs.a1) * longint'(my1)
            - longint'(coefs.a2) * longint'(my2);
        y   = quantize(sum);
        my2 = my1;
        my1 = y;
        exp_q.push_back(y);
        refresh_head();
    endtask

    // Called on a falling edge, returns on the falling edge one word period later
    task automatic apply_sample(input sample_t s);
        latest_sample = s;
        l_r_clk       = ~l_r_clk;  // Either polarity starts a pass
        toggles++;
        model_step(s);
        repeat (lr_period) @(negedge clk);
    endtask

    task automatic value_error(input sample_t expected, input sample_t actual);
        $display("Error at %0t: filtered_output expected %0d, got %0d",
                 $time, expected, actual);
        errors++;
    endtask

    // Word clock parked low so release does not look like an edge
    task automatic do_reset();
        l_r_clk = 1'b0;
        reset   = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b1;
        clear_model();
        exp_q.delete();
        refresh_head();
        assert (filtered_output == 0 && !out_valid) else begin
            $display("Output not cleared by reset");
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors, input int n);
        if (errors == start_errors) begin
            tests_passed++;
            $display("Test %s: passed, %0d samples", name, n);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", name, errors - start_errors);
        end
    endtask

    // Pop only after the rising edge that checked the head
    always @(posedge clk) begin
        pop_req <= out_valid;
        if (reset && out_valid) pulses <= pulses + 1;
    end

    always @(negedge clk) begin
        if (pop_req && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            refresh_head();
        end
    end

    a_output_value: assert property (
        @(posedge clk) disable iff (!reset)
        out_valid |-> (filtered_output == exp_head)
    ) else begin
        value_error($sampled(exp_head), $sampled(filtered_output));
    end

    a_valid_one_cycle: assert property (
        @(posedge clk) disable iff (!reset)
        out_valid |=> !out_valid
    ) else begin
        $display("out_valid stayed high for more than one cycle at %0t", $time);
        errors++;
    end

    a_valid_expected: assert property (
        @(posedge clk) disable iff (!reset)
        out_valid |-> (exp_count > 0)
    ) else begin
        $display("out_valid at %0t with no sample waiting for a result", $time);
        errors++;
    end

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int      start;
        sample_t s;
        void'($urandom(32'ha2b1_26c6));
        reset         = 1'b0;
        l_r_clk       = 1'b0;
        latest_sample = '0;
        coefs         = '0;
        pop_req       = 1'b0;
        clear_model();
        refresh_head();
        @(negedge clk);
        do_reset();

        start = errors;  // b0 = 1.0 only
        coefs    = '0;
        coefs.b0 = 16'sd16384;
        for (int i = 0; i < 8; i++) begin
            s = sample_t'($urandom);
            apply_sample(s);
            assert (filtered_output == s) else value_error(s, filtered_output);
        end
        finish_test("pass-through", start, 8);

        start = errors;
        coefs.b0 = coef_t'($urandom);
        coefs.b1 = coef_t'($urandom);
        coefs.b2 = coef_t'($urandom);
        coefs.a1 = '0;
        coefs.a2 = '0;
        for (int i = 0; i < 24; i++) apply_sample(sample_t'($urandom));
        finish_test("fir-only", start, 24);

        start = errors;  // Small coefficients keep the loop stable
        coefs.b0 = small_coef();
        coefs.b1 = small_coef();
        coefs.b2 = small_coef();
        coefs.a1 = small_coef();
        coefs.a2 = small_coef();
        for (int i = 0; i < 40; i++) apply_sample(sample_t'($urandom));
        finish_test("full-recursion", start, 40);

        start = errors;
        coefs    = '0;
        coefs.b0 = 16'sh7fff;
        coefs.b1 = 16'sh7fff;
        coefs.b2 = 16'sh7fff;
        for (int i = 0; i < 4; i++) apply_sample(16'sh7fff);  // Clamps high
        for (int i = 0; i < 4; i++) apply_sample(16'sh8000);  // Clamps low
        finish_test("saturation", start, 8);

        start = errors;
        coefs.b0 = small_coef();
        coefs.b1 = small_coef();
        coefs.b2 = small_coef();
        coefs.a1 = small_coef();
        coefs.a2 = small_coef();
        for (int i = 0; i < 4; i++) apply_sample(sample_t'($urandom));
        do_reset();
        s = sample_t'($urandom);
        apply_sample(s);
        // Zero history, so only the b0 term remains
        assert (filtered_output == quantize(longint'(coefs.b0) * longint'(s)))
        else value_error(quantize(longint'(coefs.b0) * longint'(s)), filtered_output);
        for (int i = 0; i < 11; i++) apply_sample(sample_t'($urandom));
        finish_test("reset-mid-run", start, 16);

        start = errors;
        assert (pulses == toggles) else begin
            $display("Saw %0d out_valid pulses for %0d word-clock transitions",
                     pulses, toggles);
            errors++;
        end
        finish_test("both-edges", start, toggles);

        $display("Tests passed %0d, failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hdl/biquad_types_pkg.sv
hdl/biquad_ctrl_pkg.sv
hdl/biquad_sequencer.sv
hdl/tap_store.sv
hdl/mac_accum.sv
hdl/output_quantizer.sv
hdl/biquad_filter_top.sv
dv/tb_biquad.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tb_biquad
FILELIST  := tb.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
